// ==== design/link_macros.svh ====
`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// Link pin width.
`define LINK_NIB_W 4

// Packet data and register data width.
`define LINK_BYTE_W 8

`define LINK_ADDR_W 3

// Idle cycles between DLINK beacons.
`define LINK_BEACON_GAP 16

`endif

// ==== design/link_pkg.sv ====
`include "link_macros.svh"

package link_pkg;

    // Packet type nibble, first on the wire.
    typedef enum logic [`LINK_NIB_W-1:0] {
        INIT   = 4'h0,
        ACK    = 4'h1,
        NAK    = 4'h2,
        DIDX   = 4'h5,
        DPARAM = 4'h6,
        DDIDX  = 4'h7,
        DLINK  = 4'h8,
        DTYPE  = 4'h9,
        DTEMP  = 4'hA,
        DATA0  = 4'hD
    } pkt_type_e;

    // Host register map.
    typedef enum logic [`LINK_ADDR_W-1:0] {
        CTRL     = 3'd0,
        DEV_IDX  = 3'd1,
        PARAM    = 3'd2,
        DATA_IDX = 3'd3,
        STATUS   = 3'd4,
        TYPE     = 3'd5,
        TEMP     = 3'd6,
        DATA     = 3'd7
    } reg_addr_e;

endpackage

// ==== design/pkt_tx.sv ====
`timescale 1ns/1ps
`include "link_macros.svh"

module pkt_tx (
    input  logic                    clk_50,
    input  logic                    rst,
    input  logic                    start,
    input  link_pkg::pkt_type_e     btype,
    input  logic [`LINK_BYTE_W-1:0] bdata,
    output logic [`LINK_NIB_W-1:0]  txd,
    output logic                    send,
    output logic                    busy,
    output logic                    done
);

    logic [1:0]              step;
    logic [`LINK_BYTE_W-1:0] data_q;

    always_ff @(posedge clk_50) begin
        if (start && !busy) data_q <= bdata;
    end

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            step <= '0;
            txd  <= '0;
            send <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    send <= 1'b1;
                    txd  <= btype; // Type nibble goes out first.
                    step <= '0;
                end
            end else begin
                case (step)
                    2'd0: begin
                        txd  <= data_q[7:4];
                        step <= 2'd1;
                    end
                    2'd1: begin
                        txd  <= data_q[3:0];
                        step <= 2'd2;
                    end
                    default: begin
                        // Last nibble was on the pins, release the line.
                        txd  <= '0;
                        send <= 1'b0;
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/pkt_rx.sv ====
`timescale 1ns/1ps
`include "link_macros.svh"

module pkt_rx (
    input  logic                    clk_50,
    input  logic                    rst,
    input  logic [`LINK_NIB_W-1:0]  rxd,
    input  logic                    recv,
    output link_pkg::pkt_type_e     btype,
    output logic [`LINK_BYTE_W-1:0] bdata,
    output logic                    valid,
    output logic                    frame_err
);

    logic [1:0]             cnt;
    logic [`LINK_NIB_W-1:0] type_q;
    logic [`LINK_NIB_W-1:0] high_q;

    // Nibble shift path.
    always_ff @(posedge clk_50) begin
        if (recv) begin
            case (cnt)
                2'd0:    type_q <= rxd;
                2'd1:    high_q <= rxd;
                default: begin
                    btype <= link_pkg::pkt_type_e'(type_q);
                    bdata <= {high_q, rxd};
                end
            endcase
        end
    end

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            cnt       <= '0;
            valid     <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            valid     <= 1'b0;
            frame_err <= 1'b0;
            if (recv) begin
                cnt <= (cnt == 2'd2) ? 2'd0 : cnt + 2'd1;
                if (cnt == 2'd2) valid <= 1'b1;
            end else if (cnt != 2'd0) begin
                frame_err <= 1'b1; // Strobe fell mid frame.
                cnt       <= '0;
            end
        end
    end

endmodule

// ==== design/link_regs.sv ====
`timescale 1ns/1ps
`include "link_macros.svh"

module link_regs (
    input  logic                    clk_50,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`LINK_ADDR_W-1:0] wb_adr,
    input  logic [`LINK_BYTE_W-1:0] wb_dat_w,
    output logic [`LINK_BYTE_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    output logic                    enable,
    output logic [`LINK_NIB_W-1:0]  dev_idx,
    output logic [`LINK_BYTE_W-1:0] param,
    output logic [`LINK_NIB_W-1:0]  data_idx,
    input  logic                    busy,
    input  logic                    round_done,
    input  logic                    err,
    input  logic                    link_up,
    input  logic                    cap_type,
    input  logic                    cap_temp,
    input  logic                    cap_data,
    input  logic [`LINK_BYTE_W-1:0] cap_byte
);

    logic                    single;
    logic [3:0]              err_cnt;
    logic [`LINK_BYTE_W-1:0] type_r;
    logic [`LINK_BYTE_W-1:0] temp_r;
    logic [`LINK_BYTE_W-1:0] data_r;
    logic                    req;

    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            enable   <= 1'b0;
            single   <= 1'b0;
            dev_idx  <= '0;
            param    <= '0;
            data_idx <= '0;
            err_cnt  <= '0;
            type_r   <= '0;
            temp_r   <= '0;
            data_r   <= '0;
        end else begin
            wb_ack <= req;
            if (cap_type) type_r <= cap_byte;
            if (cap_temp) temp_r <= cap_byte;
            if (cap_data) data_r <= cap_byte;
            if (err && err_cnt != 4'hF) err_cnt <= err_cnt + 4'd1;
            // Single-round mode drops enable at the end of the round.
            if ((round_done || err) && single) enable <= 1'b0;
            if (req && wb_we) begin
                case (link_pkg::reg_addr_e'(wb_adr))
                    link_pkg::CTRL: begin
                        enable <= wb_dat_w[0];
                        single <= wb_dat_w[1];
                    end
                    link_pkg::DEV_IDX:  dev_idx  <= wb_dat_w[3:0];
                    link_pkg::PARAM:    param    <= wb_dat_w;
                    link_pkg::DATA_IDX: data_idx <= wb_dat_w[3:0];
                    default: ; // Result registers are read only.
                endcase
            end
            if (req) begin
                case (link_pkg::reg_addr_e'(wb_adr))
                    link_pkg::CTRL:     wb_dat_r <= {6'b0, single, enable};
                    link_pkg::DEV_IDX:  wb_dat_r <= {4'b0, dev_idx};
                    link_pkg::PARAM:    wb_dat_r <= param;
                    link_pkg::DATA_IDX: wb_dat_r <= {4'b0, data_idx};
                    link_pkg::STATUS:   wb_dat_r <= {err_cnt, 2'b0, busy, link_up};
                    link_pkg::TYPE:     wb_dat_r <= type_r;
                    link_pkg::TEMP:     wb_dat_r <= temp_r;
                    default:            wb_dat_r <= data_r;
                endcase
            end
        end
    end

endmodule

// ==== design/link_sequencer.sv ====
`timescale 1ns/1ps
`include "link_macros.svh"

module link_sequencer (
    input  logic                    clk_50,
    input  logic                    rst,
    input  logic                    enable,
    input  logic [`LINK_NIB_W-1:0]  dev_idx,
    input  logic [`LINK_BYTE_W-1:0] param,
    input  logic [`LINK_NIB_W-1:0]  data_idx,
    output logic                    busy,
    output logic                    round_done,
    output logic                    err,
    output logic                    link_up,
    output logic                    cap_type,
    output logic                    cap_temp,
    output logic                    cap_data,
    output logic [`LINK_BYTE_W-1:0] cap_byte,
    output logic                    tx_start,
    output link_pkg::pkt_type_e     tx_btype,
    output logic [`LINK_BYTE_W-1:0] tx_bdata,
    input  logic                    tx_done,
    input  logic                    rx_valid,
    input  link_pkg::pkt_type_e     rx_btype,
    input  logic [`LINK_BYTE_W-1:0] rx_bdata,
    input  logic                    rx_frame_err
);

    // Prepare, transmit and wait-reply per master packet.
    typedef enum logic [3:0] {
        IDLE, WAIT_LINK,
        P_DIDX, T_DIDX, W_DIDX,
        P_DPARAM, T_DPARAM, W_DPARAM,
        P_DDIDX, T_DDIDX, W_DDIDX
    } state_e;

    state_e              state;
    link_pkg::pkt_type_e expect_type;
    logic                waiting;
    logic                good;
    logic                bad;

    always_comb begin
        case (state)
            W_DIDX:   expect_type = link_pkg::DTYPE;
            W_DPARAM: expect_type = link_pkg::DTEMP;
            default:  expect_type = link_pkg::DATA0;
        endcase
    end

    assign waiting = (state == W_DIDX) || (state == W_DPARAM) || (state == W_DDIDX);
    assign good    = waiting && rx_valid && (rx_btype == expect_type);
    assign bad     = waiting && (rx_frame_err || (rx_valid && rx_btype != expect_type));

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            busy       <= 1'b0;
            round_done <= 1'b0;
            err        <= 1'b0;
            link_up    <= 1'b0;
            cap_type   <= 1'b0;
            cap_temp   <= 1'b0;
            cap_data   <= 1'b0;
            cap_byte   <= '0;
            tx_start   <= 1'b0;
            tx_btype   <= link_pkg::INIT;
            tx_bdata   <= '0;
        end else begin
            tx_start   <= 1'b0;
            round_done <= 1'b0;
            err        <= 1'b0;
            cap_type   <= 1'b0;
            cap_temp   <= 1'b0;
            cap_data   <= 1'b0;
            if (good) cap_byte <= rx_bdata;
            if (bad) begin
                // NAK, wrong reply or broken frame aborts the round.
                err     <= 1'b1;
                link_up <= 1'b0;
                busy    <= 1'b0;
                state   <= enable ? WAIT_LINK : IDLE;
            end else begin
                case (state)
                    IDLE: if (enable) state <= WAIT_LINK;
                    WAIT_LINK: begin
                        if (!enable) begin
                            state <= IDLE;
                        end else if (rx_valid && rx_btype == link_pkg::DLINK) begin
                            busy  <= 1'b1;
                            state <= P_DIDX;
                        end
                    end
                    P_DIDX: begin
                        tx_start <= 1'b1;
                        tx_btype <= link_pkg::DIDX;
                        tx_bdata <= {4'h0, dev_idx};
                        state    <= T_DIDX;
                    end
                    T_DIDX: if (tx_done) state <= W_DIDX;
                    W_DIDX: begin
                        if (good) begin
                            cap_type <= 1'b1;
                            link_up  <= 1'b1;
                            state    <= P_DPARAM;
                        end
                    end
                    P_DPARAM: begin
                        tx_start <= 1'b1;
                        tx_btype <= link_pkg::DPARAM;
                        tx_bdata <= param;
                        state    <= T_DPARAM;
                    end
                    T_DPARAM: if (tx_done) state <= W_DPARAM;
                    W_DPARAM: begin
                        if (good) begin
                            cap_temp <= 1'b1;
                            state    <= P_DDIDX;
                        end
                    end
                    P_DDIDX: begin
                        tx_start <= 1'b1;
                        tx_btype <= link_pkg::DDIDX;
                        tx_bdata <= {4'h0, data_idx};
                        state    <= T_DDIDX;
                    end
                    T_DDIDX: if (tx_done) state <= W_DDIDX;
                    W_DDIDX: begin
                        if (good) begin
                            cap_data   <= 1'b1;
                            round_done <= 1'b1;
                            busy       <= 1'b0;
                            state      <= enable ? WAIT_LINK : IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

endmodule

// ==== design/sensor_device.sv ====
`timescale 1ns/1ps
`include "link_macros.svh"

module sensor_device #(
    parameter logic [`LINK_NIB_W-1:0]  DEV_IDX   = 4'h3,
    parameter logic [`LINK_BYTE_W-1:0] DEV_TYPE  = 8'hA5,
    parameter logic [`LINK_BYTE_W-1:0] TEMP_BASE = 8'h63
) (
    input  logic                   clk_50,
    input  logic                   rst,
    input  logic [`LINK_NIB_W-1:0] rxd,
    input  logic                   recv,
    output logic [`LINK_NIB_W-1:0] txd,
    output logic                   send
);

    localparam int GAP_W = $clog2(`LINK_BEACON_GAP);

    typedef enum logic [1:0] {S_IDLE, S_PARAM, S_DATA} dev_state_e;

    dev_state_e              state;
    logic [GAP_W-1:0]        gap_cnt;
    logic [3:0]              round_cnt;
    logic                    tx_start;
    link_pkg::pkt_type_e     tx_btype;
    logic [`LINK_BYTE_W-1:0] tx_bdata;
    logic                    tx_busy;
    link_pkg::pkt_type_e     rx_btype;
    logic [`LINK_BYTE_W-1:0] rx_bdata;
    logic                    rx_valid;
    logic                    rx_frame_err;

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            gap_cnt   <= '0;
            round_cnt <= '0;
            tx_start  <= 1'b0;
            tx_btype  <= link_pkg::INIT;
            tx_bdata  <= '0;
        end else begin
            tx_start <= 1'b0;
            if (rx_valid) begin
                gap_cnt <= '0;
                state   <= S_IDLE; // Anything out of order lands here.
                if (state == S_IDLE && rx_btype == link_pkg::DIDX) begin
                    tx_start <= 1'b1;
                    if (rx_bdata[3:0] == DEV_IDX) begin
                        tx_btype <= link_pkg::DTYPE;
                        tx_bdata <= DEV_TYPE;
                        state    <= S_PARAM;
                    end else begin
                        tx_btype <= link_pkg::NAK;
                        tx_bdata <= '0;
                    end
                end else if (state == S_PARAM && rx_btype == link_pkg::DPARAM) begin
                    tx_start <= 1'b1;
                    tx_btype <= link_pkg::DTEMP;
                    tx_bdata <= rx_bdata + TEMP_BASE; // Wraps mod 256.
                    state    <= S_DATA;
                end else if (state == S_DATA && rx_btype == link_pkg::DDIDX) begin
                    tx_start  <= 1'b1;
                    tx_btype  <= link_pkg::DATA0;
                    tx_bdata  <= {rx_bdata[3:0], round_cnt};
                    round_cnt <= round_cnt + 4'd1;
                end
            end else if (rx_frame_err) begin
                state <= S_IDLE;
            end else if (state == S_IDLE && !tx_busy && !tx_start) begin
                // Beacon timer runs only while the line is quiet.
                if (gap_cnt == GAP_W'(`LINK_BEACON_GAP - 1)) begin
                    gap_cnt  <= '0;
                    tx_start <= 1'b1;
                    tx_btype <= link_pkg::DLINK;
                    tx_bdata <= {4'h0, DEV_IDX};
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end
        end
    end

    pkt_tx tx_i (
        .clk_50 (clk_50),
        .rst    (rst),
        .start  (tx_start),
        .btype  (tx_btype),
        .bdata  (tx_bdata),
        .txd    (txd),
        .send   (send),
        .busy   (tx_busy),
        .done   ()
    );

    pkt_rx rx_i (
        .clk_50    (clk_50),
        .rst       (rst),
        .rxd       (rxd),
        .recv      (recv),
        .btype     (rx_btype),
        .bdata     (rx_bdata),
        .valid     (rx_valid),
        .frame_err (rx_frame_err)
    );

endmodule

// ==== design/sensor_link_top.sv ====
`timescale 1ns/1ps
`include "link_macros.svh"

module sensor_link_top (
    input  logic                    clk_50,
    input  logic                    rst,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`LINK_ADDR_W-1:0] wb_adr,
    input  logic [`LINK_BYTE_W-1:0] wb_dat_w,
    output logic [`LINK_BYTE_W-1:0] wb_dat_r,
    output logic                    wb_ack,
    output logic [`LINK_NIB_W-1:0]  m_txd,
    output logic                    m_send,
    input  logic [`LINK_NIB_W-1:0]  m_rxd,
    input  logic                    m_recv,
    output logic [`LINK_NIB_W-1:0]  s_txd,
    output logic                    s_send,
    input  logic [`LINK_NIB_W-1:0]  s_rxd,
    input  logic                    s_recv
);

    logic                    enable, busy, round_done, err, link_up;
    logic                    cap_type, cap_temp, cap_data;
    logic [`LINK_NIB_W-1:0]  dev_idx, data_idx;
    logic [`LINK_BYTE_W-1:0] param, cap_byte;
    logic                    tx_start, tx_done;
    link_pkg::pkt_type_e     tx_btype, rx_btype;
    logic [`LINK_BYTE_W-1:0] tx_bdata, rx_bdata;
    logic                    rx_valid, rx_frame_err;

    link_regs regs_i (
        .clk_50 (clk_50), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .enable (enable), .dev_idx (dev_idx), .param (param), .data_idx (data_idx),
        .busy (busy), .round_done (round_done), .err (err), .link_up (link_up),
        .cap_type (cap_type), .cap_temp (cap_temp), .cap_data (cap_data),
        .cap_byte (cap_byte)
    );

    link_sequencer seq_i (
        .clk_50 (clk_50), .rst (rst),
        .enable (enable), .dev_idx (dev_idx), .param (param), .data_idx (data_idx),
        .busy (busy), .round_done (round_done), .err (err), .link_up (link_up),
        .cap_type (cap_type), .cap_temp (cap_temp), .cap_data (cap_data),
        .cap_byte (cap_byte),
        .tx_start (tx_start), .tx_btype (tx_btype), .tx_bdata (tx_bdata),
        .tx_done (tx_done),
        .rx_valid (rx_valid), .rx_btype (rx_btype), .rx_bdata (rx_bdata),
        .rx_frame_err (rx_frame_err)
    );

    pkt_tx m_tx_i (
        .clk_50 (clk_50), .rst (rst),
        .start (tx_start), .btype (tx_btype), .bdata (tx_bdata),
        .txd (m_txd), .send (m_send), .busy (), .done (tx_done)
    );

    pkt_rx m_rx_i (
        .clk_50 (clk_50), .rst (rst),
        .rxd (m_rxd), .recv (m_recv),
        .btype (rx_btype), .bdata (rx_bdata), .valid (rx_valid),
        .frame_err (rx_frame_err)
    );

    // Remote endpoint with its default identity.
    sensor_device dev_i (
        .clk_50 (clk_50), .rst (rst),
        .rxd (s_rxd), .recv (s_recv),
        .txd (s_txd), .send (s_send)
    );

endmodule

// ==== tb/sensor_link_tb.sv ====
`timescale 1ns/1ps
`include "link_macros.svh"

module sensor_link_tb;

    localparam int ROWS           = 6;
    localparam int LIMIT          = ROWS * 200 + 500;
    localparam int MAX_BUSY_POLLS = 40; // A round is at most about 90 cycles.

    // Identity of the device under the top level.
    localparam logic [3:0] DEV_ADDR  = 4'h3;
    localparam logic [7:0] DEV_TYPE  = 8'hA5;
    localparam logic [7:0] TEMP_BASE = 8'h63;

    typedef struct packed {
        logic [3:0] dev_idx;
        logic [7:0] param;
        logic [3:0] data_idx;
        logic       expect_nak;
    } row_t;

    logic                    clk_50;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`LINK_ADDR_W-1:0] wb_adr;
    logic [`LINK_BYTE_W-1:0] wb_dat_w;
    logic [`LINK_BYTE_W-1:0] wb_dat_r;
    logic                    wb_ack;
    logic [`LINK_NIB_W-1:0]  m_txd;
    logic                    m_send;
    logic [`LINK_NIB_W-1:0]  m_rxd;
    logic                    m_recv;
    logic [`LINK_NIB_W-1:0]  s_txd;
    logic                    s_send;
    logic [`LINK_NIB_W-1:0]  s_rxd;
    logic                    s_recv;

    row_t        rows [ROWS];
    string       reg_names [8] = '{"CTRL", "DEV_IDX", "PARAM", "DATA_IDX",
                                   "STATUS", "TYPE", "TEMP", "DATA"};
    int unsigned cycles = 0;

    // Pins wired back to back, as on the board.
    assign s_rxd  = m_txd;
    assign s_recv = m_send;
    assign m_rxd  = s_txd;
    assign m_recv = s_send;

    sensor_link_top dut_i (
        .clk_50 (clk_50), .rst (rst),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .m_txd (m_txd), .m_send (m_send), .m_rxd (m_rxd), .m_recv (m_recv),
        .s_txd (s_txd), .s_send (s_send), .s_rxd (s_rxd), .s_recv (s_recv)
    );

    initial begin
        clk_50 = 1'b0;
        forever #2 clk_50 = ~clk_50;
    end

    always @(posedge clk_50) begin
        cycles <= cycles + 1;
        assert (cycles < LIMIT) else begin
            $display("Timeout: the run did not finish within %0d cycles.", LIMIT);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        assert (got === expected) else begin
            $display("[ERROR] %s got 0x%h, expected 0x%h", name, got, expected);
            abort_run();
        end
    endtask

    task automatic write_reg(input link_pkg::reg_addr_e adr, input logic [7:0] dat);
        @(posedge clk_50);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        do @(posedge clk_50); while (!wb_ack);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic read_reg(input link_pkg::reg_addr_e adr, output logic [7:0] dat);
        @(posedge clk_50);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        do @(posedge clk_50); while (!wb_ack);
        dat    = wb_dat_r; // Valid while ack is high.
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic check_reg(input link_pkg::reg_addr_e adr, input logic [7:0] expected);
        logic [7:0] got;
        read_reg(adr, got);
        check_value(reg_names[adr], got, expected);
    endtask

    initial begin
        logic [7:0] rd;
        logic [7:0] exp_type;
        logic [7:0] exp_temp;
        logic [7:0] exp_data;
        logic [3:0] exp_err;
        logic       exp_link;
        int         i;
        int         polls;
        int         good_rounds;

        void'($urandom(32'h450a_f067));
        rows[0] = '{DEV_ADDR, 8'($urandom), 4'h1, 1'b0};
        rows[1] = '{DEV_ADDR, 8'hFF, 4'h2, 1'b0}; // TEMP wraps to 62.
        rows[2] = '{4'h9, 8'($urandom), 4'h4, 1'b1}; // Wrong index, NAK.
        rows[3] = '{DEV_ADDR, 8'($urandom), 4'h6, 1'b0};
        rows[4] = '{DEV_ADDR, 8'($urandom), 4'hA, 1'b0};
        rows[5] = '{DEV_ADDR, 8'($urandom), 4'hF, 1'b0};

        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (5) @(posedge clk_50);
        rst <= 1'b0;

        // Both lines quiet until the first beacon.
        repeat (`LINK_BEACON_GAP) begin
            @(posedge clk_50);
            check_value("s_send", {7'b0, s_send}, 8'h00);
            check_value("m_send", {7'b0, m_send}, 8'h00);
        end
        while (!s_send) begin
            @(posedge clk_50);
            check_value("m_send", {7'b0, m_send}, 8'h00);
        end
        for (i = 0; i < 8; i++) check_reg(link_pkg::reg_addr_e'(i), 8'h00);

        write_reg(link_pkg::DEV_IDX, 8'hF7);
        write_reg(link_pkg::PARAM, 8'h5A);
        write_reg(link_pkg::DATA_IDX, 8'hEC);
        write_reg(link_pkg::CTRL, 8'hFE); // Single set, enable clear.
        check_reg(link_pkg::DEV_IDX, 8'h07);
        check_reg(link_pkg::PARAM, 8'h5A);
        check_reg(link_pkg::DATA_IDX, 8'h0C);
        check_reg(link_pkg::CTRL, 8'h02);
        for (i = 4; i < 8; i++) write_reg(link_pkg::reg_addr_e'(i), 8'hFF);
        for (i = 4; i < 8; i++) check_reg(link_pkg::reg_addr_e'(i), 8'h00);
        write_reg(link_pkg::CTRL, 8'h00);
        check_reg(link_pkg::CTRL, 8'h00);

        exp_type    = 8'h00;
        exp_temp    = 8'h00;
        exp_data    = 8'h00;
        exp_err     = 4'h0;
        exp_link    = 1'b0;
        good_rounds = 0;
        for (i = 0; i < ROWS; i++) begin
            write_reg(link_pkg::DEV_IDX, {4'h0, rows[i].dev_idx});
            write_reg(link_pkg::PARAM, rows[i].param);
            write_reg(link_pkg::DATA_IDX, {4'h0, rows[i].data_idx});
            write_reg(link_pkg::CTRL, 8'h03);
            do read_reg(link_pkg::CTRL, rd); while (rd[0]);
            if (rows[i].expect_nak) begin
                if (exp_err != 4'hF) exp_err = exp_err + 4'd1;
                exp_link = 1'b0;
            end else begin
                exp_type = DEV_TYPE;
                exp_temp = rows[i].param + TEMP_BASE;
                exp_data = {rows[i].data_idx, 4'(good_rounds)};
                exp_link = 1'b1;
                good_rounds++;
            end
            check_reg(link_pkg::STATUS, {exp_err, 3'b000, exp_link});
            check_reg(link_pkg::TYPE, exp_type);
            check_reg(link_pkg::TEMP, exp_temp);
            check_reg(link_pkg::DATA, exp_data);
        end

        // Free-running rounds with single clear.
        write_reg(link_pkg::CTRL, 8'h01);
        repeat (2) begin
            rd = exp_data;
            while (rd == exp_data) read_reg(link_pkg::DATA, rd);
            exp_data = {rows[ROWS-1].data_idx, 4'(good_rounds)};
            good_rounds++;
            check_value("DATA", rd, exp_data);
            check_reg(link_pkg::CTRL, 8'h01);
        end

        write_reg(link_pkg::CTRL, 8'h00);
        polls = 0;
        rd    = 8'h02;
        while (rd[1]) begin
            read_reg(link_pkg::STATUS, rd);
            polls++;
            assert (polls <= MAX_BUSY_POLLS) else begin
                $display("STATUS busy still set %0d reads after enable was cleared.", polls);
                abort_run();
            end
        end
        check_reg(link_pkg::CTRL, 8'h00);

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+design
design/link_pkg.sv
design/pkt_tx.sv
design/pkt_rx.sv
design/link_regs.sv
design/link_sequencer.sv
design/sensor_device.sv
design/sensor_link_top.sv
tb/sensor_link_tb.sv

// ==== Bender.yml ====
package:
  name: sensor_link

sources:
  - include_dirs:
      - design
    files:
      - design/link_pkg.sv
      - design/pkt_tx.sv
      - design/pkt_rx.sv
      - design/link_regs.sv
      - design/link_sequencer.sv
      - design/sensor_device.sv
      - design/sensor_link_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/sensor_link_tb.sv
